// File: source/bus_config.svh
// Build constants for the thread data-memory port, included by every RTL file that sizes logic
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// Hardware threads sharing the port, one request slot each
`define NUM_THREADS 4

// Byte address width of a request and of the bus
`define ADDR_W 32

// Width of one bus beat; a 32-bit request uses one half of it
`define BUS_DATA_W 64

// Depth of the target memory in bus words
`define RAM_WORDS 256

// Cycles from AR acceptance until the target raises R valid
`define RAM_READ_LATENCY 3

`endif

// File: source/bus_pkg.sv
// Shared thread, register and slot types for the data-memory port and its testbench
`include "bus_config.svh"

package bus_pkg;

  // Thread number, also used as the ID on every bus channel
  typedef logic [$clog2(`NUM_THREADS)-1:0] thread_t;

  // Register file index that a load result is written back to
  typedef logic [2:0] wb_reg_t;

  // One outstanding request per thread
  // The mask selects bytes of the 32-bit word at addr, both for stores and for
  // the lane extraction on loads
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [3:0]         mask;
    logic [31:0]        wdata;
    wb_reg_t            wb_reg;
  } slot_t;

endpackage

// File: source/axi_bus_if.sv
// Single-beat AXI channel bundle between the issue engines, the observers and the RAM target
`timescale 1ns/1ps
`include "bus_config.svh"

interface axi_bus_if;

  bus_pkg::thread_t         awid;
  logic [`ADDR_W-1:0]       awaddr;
  logic                     awvalid;
  logic                     awready;

  logic [`BUS_DATA_W-1:0]   wdata;
  logic [`BUS_DATA_W/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;

  bus_pkg::thread_t         bid;
  logic                     bvalid;
  logic                     bready;

  bus_pkg::thread_t         arid;
  logic [`ADDR_W-1:0]       araddr;
  logic                     arvalid;
  logic                     arready;

  bus_pkg::thread_t         rid;
  logic [`BUS_DATA_W-1:0]   rdata;
  logic                     rvalid;
  logic                     rready;

  // The port never back-pressures responses
  assign bready = 1'b1;
  assign rready = 1'b1;

  modport write_master (output awid, awaddr, awvalid, wdata, wstrb, wvalid,
                        input awready, wready, bid, bvalid, bready);

  modport read_master (output arid, araddr, arvalid,
                       input arready, rid, rvalid, rready);

  modport observer (input bid, bvalid, bready, rid, rdata, rvalid, rready);

  modport slave (input awid, awaddr, awvalid, wdata, wstrb, wvalid, bready,
                 input arid, araddr, arvalid, rready,
                 output awready, wready, bid, bvalid, arready, rid, rdata, rvalid);

endinterface

// File: source/thread_slot_table.sv
// Per-thread request slots with pending read/write tracking and the stall flags fed back to the core
`timescale 1ns/1ps
`include "bus_config.svh"

module thread_slot_table
(
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    req_valid,
  input  logic                    req_write,
  input  bus_pkg::thread_t        req_thread,
  input  logic [`ADDR_W-1:0]      req_addr,
  input  logic [31:0]             req_wdata,
  input  logic [3:0]              req_mask,
  input  bus_pkg::wb_reg_t        req_wb_reg,
  axi_bus_if.observer             bus,
  output bus_pkg::slot_t          slots [`NUM_THREADS],
  output logic [`NUM_THREADS-1:0] pending_write,
  output logic [`NUM_THREADS-1:0] pending_read,
  output logic [`NUM_THREADS-1:0] stall
);

  logic [`NUM_THREADS-1:0] req_hit;
  logic [`NUM_THREADS-1:0] b_ack;
  logic [`NUM_THREADS-1:0] r_ack;

  // Decode the requesting thread and the responding IDs into one-hot vectors
  always_comb
  begin
    for (int i = 0; i < `NUM_THREADS; i++)
    begin
      req_hit[i] = req_valid && (req_thread == bus_pkg::thread_t'(i));
      b_ack[i]   = bus.bvalid && bus.bready && (bus.bid == bus_pkg::thread_t'(i));
      r_ack[i]   = bus.rvalid && bus.rready && (bus.rid == bus_pkg::thread_t'(i));
    end
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      pending_write <= '0;
      pending_read  <= '0;
      stall         <= '0;
    end
    else
    begin
      pending_write <= (pending_write & ~b_ack) | (req_hit & {`NUM_THREADS{req_write}});
      pending_read  <= (pending_read & ~r_ack) | (req_hit & {`NUM_THREADS{!req_write}});
      // Registered so the stall bit trails the pending bit by one cycle on both edges
      stall         <= pending_write | pending_read;
    end
  end

  // Slot contents stay put until the same thread requests again
  always_ff @(posedge CLK)
  begin
    for (int i = 0; i < `NUM_THREADS; i++)
    begin
      if (req_hit[i])
      begin
        slots[i] <= '{addr: req_addr, mask: req_mask, wdata: req_wdata, wb_reg: req_wb_reg};
      end
    end
  end

  // A thread only requests again once its previous access has completed
  a_no_request_while_pending: assert property (@(posedge CLK) disable iff (RST)
    req_valid |-> !(pending_write[req_thread] || pending_read[req_thread]))
    else $error("request from thread %0d while its previous access is pending", req_thread);

endmodule

// File: source/axi_write_issue.sv
// Write issue engine that scans the slots in turn and drives one AW and one W beat per store
`timescale 1ns/1ps
`include "bus_config.svh"

module axi_write_issue
(
  input  logic                    CLK,
  input  logic                    RST,
  input  bus_pkg::slot_t          slots [`NUM_THREADS],
  input  logic [`NUM_THREADS-1:0] pending_write,
  axi_bus_if.write_master         bus
);

  bus_pkg::thread_t        ptr;
  bus_pkg::slot_t          cur;
  logic                    busy;
  logic                    start;
  logic [`NUM_THREADS-1:0] sent;
  logic [`NUM_THREADS-1:0] issue_hit;
  logic [`NUM_THREADS-1:0] b_ack;

  assign cur   = slots[ptr];
  assign start = !busy && pending_write[ptr] && !sent[ptr];

  always_comb
  begin
    for (int i = 0; i < `NUM_THREADS; i++)
    begin
      issue_hit[i] = start && (ptr == bus_pkg::thread_t'(i));
      b_ack[i]     = bus.bvalid && bus.bready && (bus.bid == bus_pkg::thread_t'(i));
    end
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      ptr         <= '0;
      busy        <= 1'b0;
      sent        <= '0;
      bus.awvalid <= 1'b0;
      bus.wvalid  <= 1'b0;
    end
    else
    begin
      // A thread stays marked as sent until its B beat comes back
      sent <= (sent & ~b_ack) | issue_hit;
      if (start)
      begin
        busy        <= 1'b1;
        bus.awvalid <= 1'b1;
        bus.wvalid  <= 1'b1;
      end
      else if (busy)
      begin
        bus.awvalid <= bus.awvalid && !bus.awready;
        bus.wvalid  <= bus.wvalid && !bus.wready;
        // AW and W may complete on different edges, move on once both are gone
        if ((!bus.awvalid || bus.awready) && (!bus.wvalid || bus.wready))
        begin
          busy <= 1'b0;
          ptr  <= ptr + 1'b1;
        end
      end
      else
      begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (start)
    begin
      bus.awid   <= ptr;
      bus.awaddr <= cur.addr;
      bus.wdata  <= {cur.wdata, cur.wdata};
      // Bit 2 of the address picks the 32-bit half of the bus word
      bus.wstrb  <= cur.addr[2] ? {cur.mask, 4'b0000} : {4'b0000, cur.mask};
    end
  end

  a_aw_stable: assert property (@(posedge CLK) disable iff (RST)
    bus.awvalid && !bus.awready |=> bus.awvalid && $stable(bus.awaddr) && $stable(bus.wdata))
    else $error("write address or data changed while AW was waiting for ready");

endmodule

// File: source/axi_read_issue.sv
// Read issue engine that scans the slots in turn and drives one AR beat per pending load
`timescale 1ns/1ps
`include "bus_config.svh"

module axi_read_issue
(
  input  logic                    CLK,
  input  logic                    RST,
  input  bus_pkg::slot_t          slots [`NUM_THREADS],
  input  logic [`NUM_THREADS-1:0] pending_read,
  axi_bus_if.read_master          bus
);

  bus_pkg::thread_t        ptr;
  logic                    start;
  logic [`NUM_THREADS-1:0] sent;
  logic [`NUM_THREADS-1:0] issue_hit;
  logic [`NUM_THREADS-1:0] r_ack;

  assign start = !bus.arvalid && pending_read[ptr] && !sent[ptr];

  always_comb
  begin
    for (int i = 0; i < `NUM_THREADS; i++)
    begin
      issue_hit[i] = start && (ptr == bus_pkg::thread_t'(i));
      r_ack[i]     = bus.rvalid && bus.rready && (bus.rid == bus_pkg::thread_t'(i));
    end
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      ptr         <= '0;
      sent        <= '0;
      bus.arvalid <= 1'b0;
    end
    else
    begin
      sent <= (sent & ~r_ack) | issue_hit;
      if (start)
      begin
        bus.arvalid <= 1'b1;
      end
      // The pointer holds on the issued thread while the target back-pressures
      else if (!bus.arvalid || bus.arready)
      begin
        bus.arvalid <= 1'b0;
        ptr         <= ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (start)
    begin
      bus.arid   <= ptr;
      bus.araddr <= slots[ptr].addr;
    end
  end

endmodule

// File: source/load_formatter.sv
// Two-stage load return path that picks the word half and lanes and emits the register write-back
`timescale 1ns/1ps
`include "bus_config.svh"

module load_formatter
(
  input  logic             CLK,
  input  logic             RST,
  axi_bus_if.observer      bus,
  input  bus_pkg::slot_t   slots [`NUM_THREADS],
  output logic             load_valid,
  output bus_pkg::thread_t load_thread,
  output bus_pkg::wb_reg_t load_wb_reg,
  output logic [31:0]      load_data
);

  logic                   r_valid_q;
  bus_pkg::thread_t       r_id_q;
  logic [`BUS_DATA_W-1:0] r_data_q;
  bus_pkg::slot_t         sel_slot;
  logic [31:0]            half_word;
  logic [31:0]            formatted;

  // Stage one captures the R beat as it arrives
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      r_valid_q <= 1'b0;
      load_valid <= 1'b0;
    end
    else
    begin
      r_valid_q <= bus.rvalid && bus.rready;
      load_valid <= r_valid_q;
    end
  end

  always_ff @(posedge CLK)
  begin
    r_id_q   <= bus.rid;
    r_data_q <= bus.rdata;
  end

  // The slot of the returning thread still holds the request's address and mask
  assign sel_slot  = slots[r_id_q];
  assign half_word = sel_slot.addr[2] ? r_data_q[`BUS_DATA_W-1 -: 32] : r_data_q[31:0];

  always_comb
  begin
    case (sel_slot.mask)
      4'b0001: formatted = {24'd0, half_word[7:0]};
      4'b0010: formatted = {24'd0, half_word[15:8]};
      4'b0100: formatted = {24'd0, half_word[23:16]};
      4'b1000: formatted = {24'd0, half_word[31:24]};
      4'b0011: formatted = {16'd0, half_word[15:0]};
      4'b1100: formatted = {16'd0, half_word[31:16]};
      default: formatted = half_word;
    endcase
  end

  // Stage two registers the formatted word with its thread and register index
  always_ff @(posedge CLK)
  begin
    load_thread <= r_id_q;
    load_wb_reg <= sel_slot.wb_reg;
    load_data   <= formatted;
  end

endmodule

// File: source/axi_ram_target.sv
// AXI RAM target with byte strobes and a fixed read latency, used as the memory behind the port
`timescale 1ns/1ps
`include "bus_config.svh"

module axi_ram_target
(
  input logic      CLK,
  input logic      RST,
  axi_bus_if.slave bus
);

  localparam int IDX_W = $clog2(`RAM_WORDS);
  localparam int CNT_W = $clog2(`RAM_READ_LATENCY + 1);

  logic [`BUS_DATA_W-1:0]   mem [`RAM_WORDS];
  logic                     aw_held;
  logic                     w_held;
  bus_pkg::thread_t         aw_id;
  logic [IDX_W-1:0]         aw_idx;
  logic [`BUS_DATA_W-1:0]   w_data;
  logic [`BUS_DATA_W/8-1:0] w_strb;
  logic                     do_write;
  logic                     rd_busy;
  logic [CNT_W-1:0]         rd_cnt;
  logic [IDX_W-1:0]         rd_idx;

  // Each channel takes one beat and then waits until the write is done
  assign bus.awready = !aw_held;
  assign bus.wready  = !w_held;
  assign bus.arready = !rd_busy;
  assign do_write    = aw_held && w_held && (!bus.bvalid || bus.bready);

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      aw_held    <= 1'b0;
      w_held     <= 1'b0;
      bus.bvalid <= 1'b0;
      rd_busy    <= 1'b0;
      rd_cnt     <= '0;
      bus.rvalid <= 1'b0;
    end
    else
    begin
      aw_held    <= do_write ? 1'b0 : (aw_held || bus.awvalid);
      w_held     <= do_write ? 1'b0 : (w_held || bus.wvalid);
      bus.bvalid <= do_write || (bus.bvalid && !bus.bready);
      if (bus.arvalid && bus.arready)
      begin
        rd_busy <= 1'b1;
        // The count runs out one edge before R valid rises
        rd_cnt  <= CNT_W'(`RAM_READ_LATENCY - 2);
      end
      else if (bus.rvalid)
      begin
        bus.rvalid <= !bus.rready;
        rd_busy    <= !bus.rready;
      end
      else if (rd_busy)
      begin
        if (rd_cnt == '0)
          bus.rvalid <= 1'b1;
        else
          rd_cnt <= rd_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (bus.awvalid && bus.awready)
    begin
      aw_id  <= bus.awid;
      aw_idx <= bus.awaddr[3 +: IDX_W];
    end
    if (bus.wvalid && bus.wready)
    begin
      w_data <= bus.wdata;
      w_strb <= bus.wstrb;
    end
    if (do_write)
    begin
      bus.bid <= aw_id;
      for (int b = 0; b < `BUS_DATA_W / 8; b++)
      begin
        if (w_strb[b])
          mem[aw_idx][b*8 +: 8] <= w_data[b*8 +: 8];
      end
    end
    if (bus.arvalid && bus.arready)
    begin
      bus.rid <= bus.arid;
      rd_idx  <= bus.araddr[3 +: IDX_W];
    end
    if (rd_busy && !bus.rvalid && (rd_cnt == '0))
      bus.rdata <= mem[rd_idx];
  end

  a_read_latency: assert property (@(posedge CLK) disable iff (RST)
    bus.arvalid && bus.arready |-> ##(`RAM_READ_LATENCY) bus.rvalid)
    else $error("read data did not appear %0d cycles after AR", `RAM_READ_LATENCY);

endmodule

// File: source/thread_bus_unit.sv
// Top level of the thread data-memory port with its RAM target, driven by the core's request ports
`timescale 1ns/1ps
`include "bus_config.svh"

module thread_bus_unit
(
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    req_valid,
  input  logic                    req_write,
  input  bus_pkg::thread_t        req_thread,
  input  logic [`ADDR_W-1:0]      req_addr,
  input  logic [31:0]             req_wdata,
  input  logic [3:0]              req_mask,
  input  bus_pkg::wb_reg_t        req_wb_reg,
  output logic [`NUM_THREADS-1:0] stall,
  output logic                    load_valid,
  output bus_pkg::thread_t        load_thread,
  output bus_pkg::wb_reg_t        load_wb_reg,
  output logic [31:0]             load_data
);

  bus_pkg::slot_t          slots [`NUM_THREADS];
  logic [`NUM_THREADS-1:0] pending_write;
  logic [`NUM_THREADS-1:0] pending_read;

  axi_bus_if bus ();

  thread_slot_table slot_table_inst (
    .CLK(CLK), .RST(RST),
    .req_valid(req_valid), .req_write(req_write), .req_thread(req_thread),
    .req_addr(req_addr), .req_wdata(req_wdata), .req_mask(req_mask),
    .req_wb_reg(req_wb_reg), .bus(bus), .slots(slots),
    .pending_write(pending_write), .pending_read(pending_read), .stall(stall)
  );

  axi_write_issue write_issue_inst (
    .CLK(CLK), .RST(RST), .slots(slots), .pending_write(pending_write), .bus(bus)
  );

  axi_read_issue read_issue_inst (
    .CLK(CLK), .RST(RST), .slots(slots), .pending_read(pending_read), .bus(bus)
  );

  load_formatter load_formatter_inst (
    .CLK(CLK), .RST(RST), .bus(bus), .slots(slots),
    .load_valid(load_valid), .load_thread(load_thread),
    .load_wb_reg(load_wb_reg), .load_data(load_data)
  );

  axi_ram_target ram_target_inst (
    .CLK(CLK), .RST(RST), .bus(bus)
  );

endmodule

// File: tb/tb_thread_bus_unit.sv
// Self-checking testbench that runs stores and loads from all threads through the port and checks them with assertions
`timescale 1ns/1ps
`include "bus_config.svh"

module tb_thread_bus_unit;

  localparam int CLK_PERIOD     = 4;
  localparam int RANDOM_REQS    = 160;
  localparam int MAX_REQS       = 200;
  localparam int CYCLES_PER_REQ = 40;
  localparam logic [3:0] LANE_MASKS [6] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                            4'b0011, 4'b1100};

  logic                    CLK;
  logic                    RST;
  logic                    req_valid;
  logic                    req_write;
  bus_pkg::thread_t        req_thread;
  logic [`ADDR_W-1:0]      req_addr;
  logic [31:0]             req_wdata;
  logic [3:0]              req_mask;
  bus_pkg::wb_reg_t        req_wb_reg;
  logic [`NUM_THREADS-1:0] stall;
  logic                    load_valid;
  bus_pkg::thread_t        load_thread;
  bus_pkg::wb_reg_t        load_wb_reg;
  logic [31:0]             load_data;

  // Reference memory covering the low 2 KB, one entry per byte
  logic [7:0]              ref_mem [2048];
  logic                    word_written [512];

  // Expectations per thread, set when its request is driven
  logic [31:0]             exp_data [`NUM_THREADS];
  bus_pkg::wb_reg_t        exp_reg [`NUM_THREADS];
  logic [`NUM_THREADS-1:0] is_load;

  // Tracking per thread, kept by the monitor
  logic [`NUM_THREADS-1:0] outstanding;
  logic [`NUM_THREADS-1:0] stall_q;
  logic [`NUM_THREADS-1:0] req_age1;
  logic [`NUM_THREADS-1:0] req_age2;
  logic [1:0]              window [`NUM_THREADS];
  logic [1:0]              got [`NUM_THREADS];

  integer seed;
  int     req_count;
  int     mismatch_count;
  int     protocol_errors;

  thread_bus_unit thread_bus_unit_inst (
    .CLK(CLK), .RST(RST),
    .req_valid(req_valid), .req_write(req_write), .req_thread(req_thread),
    .req_addr(req_addr), .req_wdata(req_wdata), .req_mask(req_mask),
    .req_wb_reg(req_wb_reg), .stall(stall),
    .load_valid(load_valid), .load_thread(load_thread),
    .load_wb_reg(load_wb_reg), .load_data(load_data)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic logic [31:0] word_addr(input int t, input logic [6:0] word);
    return {21'd0, t[1:0], word, 2'b00};
  endfunction

  function automatic void update_reference(input logic [31:0] addr, input logic [3:0] mask,
                                           input logic [31:0] data);
    for (int i = 0; i < 4; i++)
    begin
      if (mask[i])
        ref_mem[{addr[10:2], i[1:0]}] = data[8*i +: 8];
    end
    if (mask == 4'hF)
      word_written[addr[10:2]] = 1'b1;
  endfunction

  // Byte lane i of a word sits at byte address addr + i
  function automatic logic [31:0] expected_load(input logic [31:0] addr, input logic [3:0] mask);
    logic [31:0] mem_word;
    int          lane;
    lane = 0;
    for (int i = 0; i < 4; i++)
    begin
      mem_word[8*i +: 8] = ref_mem[{addr[10:2], i[1:0]}];
      if (mask[i])
        lane = i;
    end
    case (mask)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: return {24'd0, mem_word[8*lane +: 8]};
      4'b0011: return {16'd0, mem_word[15:0]};
      4'b1100: return {16'd0, mem_word[31:16]};
      default: return mem_word;
    endcase
  endfunction

  task automatic wait_thread_free(input int t);
    @(posedge CLK);
    while (outstanding[t] || window[t] != 2'd0)
      @(posedge CLK);
  endtask

  task automatic wait_all_idle();
    logic busy;
    busy = 1'b1;
    while (busy)
    begin
      @(posedge CLK);
      busy = |outstanding;
      for (int i = 0; i < `NUM_THREADS; i++)
      begin
        if (window[i] != 2'd0)
          busy = 1'b1;
      end
    end
  endtask

  task automatic issue_request(input int t, input logic write, input logic [6:0] word,
                               input logic [3:0] mask, input logic [31:0] data,
                               input bus_pkg::wb_reg_t wb_reg);
    logic [31:0] addr;
    addr = word_addr(t, word);
    wait_thread_free(t);
    req_valid  <= 1'b1;
    req_write  <= write;
    req_thread <= bus_pkg::thread_t'(t);
    req_addr   <= addr;
    req_wdata  <= data;
    req_mask   <= mask;
    req_wb_reg <= wb_reg;
    if (write)
      update_reference(addr, mask, data);
    else
    begin
      exp_data[t] = expected_load(addr, mask);
      exp_reg[t]  = wb_reg;
    end
    is_load[t] = !write;
    req_count++;
    @(posedge CLK);
    req_valid <= 1'b0;
  endtask

  // Follows captures, stall edges and load deliveries for every thread
  always @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      outstanding <= '0;
      stall_q     <= '0;
      req_age1    <= '0;
      req_age2    <= '0;
      for (int t = 0; t < `NUM_THREADS; t++)
      begin
        window[t] <= 2'd0;
        got[t]    <= 2'd0;
      end
    end
    else
    begin
      stall_q  <= stall;
      req_age2 <= req_age1;
      for (int t = 0; t < `NUM_THREADS; t++)
      begin
        req_age1[t] <= req_valid && (req_thread == bus_pkg::thread_t'(t));
        if (req_valid && (req_thread == bus_pkg::thread_t'(t)))
        begin
          outstanding[t] <= 1'b1;
          got[t]         <= 2'd0;
        end
        else
        begin
          if (stall_q[t] && !stall[t])
            outstanding[t] <= 1'b0;
          if (load_valid && (load_thread == bus_pkg::thread_t'(t)) && got[t] != 2'd3)
            got[t] <= got[t] + 2'd1;
        end
        // A load result may still arrive up to two cycles after the stall bit falls
        if (stall_q[t] && !stall[t] && is_load[t])
          window[t] <= 2'd2;
        else if (window[t] != 2'd0)
          window[t] <= window[t] - 2'd1;
      end
    end
  end

  a_load_expected: assert property (@(posedge CLK) disable iff (RST)
    load_valid |-> is_load[load_thread] && got[load_thread] == 2'd0
                   && (outstanding[load_thread] || window[load_thread] != 2'd0))
    else
    begin
      protocol_errors++;
      $display("ERROR at %0t: load result for thread %0d without a load waiting for it",
               $time, $sampled(load_thread));
    end

  a_load_data: assert property (@(posedge CLK) disable iff (RST)
    load_valid |-> load_data == exp_data[load_thread])
    else
    begin
      mismatch_count++;
      $display("MISMATCH at %0t: thread %0d load data %h, expected %h", $time,
               $sampled(load_thread), $sampled(load_data), exp_data[$sampled(load_thread)]);
    end

  a_load_reg: assert property (@(posedge CLK) disable iff (RST)
    load_valid |-> load_wb_reg == exp_reg[load_thread])
    else
    begin
      mismatch_count++;
      $display("MISMATCH at %0t: thread %0d load register %0d, expected %0d", $time,
               $sampled(load_thread), $sampled(load_wb_reg), exp_reg[$sampled(load_thread)]);
    end

  for (genvar t = 0; t < `NUM_THREADS; t++)
  begin : g_thread
    a_stall_rise: assert property (@(posedge CLK) disable iff (RST)
      req_age2[t] |-> stall[t])
      else
      begin
        protocol_errors++;
        $display("ERROR at %0t: stall of thread %0d did not rise after its request", $time, t);
      end

    a_stall_cause: assert property (@(posedge CLK) disable iff (RST)
      !stall_q[t] && stall[t] |-> req_age2[t])
      else
      begin
        protocol_errors++;
        $display("ERROR at %0t: stall of thread %0d rose without a request", $time, t);
      end

    a_stall_fall: assert property (@(posedge CLK) disable iff (RST)
      stall_q[t] && !stall[t] |-> outstanding[t])
      else
      begin
        protocol_errors++;
        $display("ERROR at %0t: stall of thread %0d fell with nothing outstanding", $time, t);
      end

    a_load_delivered: assert property (@(posedge CLK) disable iff (RST)
      window[t] == 2'd1 |-> got[t] == 2'd1
                            || (got[t] == 2'd0 && load_valid
                                && load_thread == bus_pkg::thread_t'(t)))
      else
      begin
        protocol_errors++;
        $display("ERROR at %0t: thread %0d did not get exactly one load result", $time, t);
      end
  end

  initial
  begin
    #(MAX_REQS * CYCLES_PER_REQ * CLK_PERIOD);
    $display("Timeout: the tests did not complete within %0d cycles",
             MAX_REQS * CYCLES_PER_REQ);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    logic [31:0] rnd;
    logic [31:0] data;
    logic [6:0]  word;
    int          t;
    seed            = 32'h39610542;
    CLK             = 1'b0;
    RST             = 1'b1;
    req_valid       = 1'b0;
    req_write       = 1'b0;
    req_thread      = '0;
    req_addr        = '0;
    req_wdata       = '0;
    req_mask        = '0;
    req_wb_reg      = '0;
    is_load         = '0;
    req_count       = 0;
    mismatch_count  = 0;
    protocol_errors = 0;
    for (int i = 0; i < 512; i++)
      word_written[i] = 1'b0;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    // Full words in the lower and the upper half of one bus word
    issue_request(0, 1'b1, 7'd4, 4'hF, 32'hA5C3_0F12, 3'd0);
    issue_request(0, 1'b1, 7'd5, 4'hF, 32'h1E2D_3C4B, 3'd0);
    issue_request(0, 1'b0, 7'd4, 4'hF, 32'h0, 3'd1);
    issue_request(0, 1'b0, 7'd5, 4'hF, 32'h0, 3'd2);

    // Every byte and halfword lane from both halves
    issue_request(1, 1'b1, 7'd8, 4'hF, 32'h8899_AABB, 3'd0);
    issue_request(1, 1'b1, 7'd9, 4'hF, 32'hF1E2_D3C4, 3'd0);
    for (int m = 0; m < 6; m++)
    begin
      issue_request(1, 1'b0, 7'd8, LANE_MASKS[m], 32'h0, 3'(m));
      issue_request(1, 1'b0, 7'd9, LANE_MASKS[m], 32'h0, 3'(m + 1));
    end

    // Masked stores over full words, read back whole
    issue_request(2, 1'b1, 7'd20, 4'hF, 32'h0123_4567, 3'd0);
    issue_request(2, 1'b1, 7'd20, 4'b0110, 32'hFEDC_BA98, 3'd0);
    issue_request(2, 1'b0, 7'd20, 4'hF, 32'h0, 3'd3);
    issue_request(2, 1'b1, 7'd21, 4'hF, 32'h7654_3210, 3'd0);
    issue_request(2, 1'b1, 7'd21, 4'b1001, 32'h9A8B_7C6D, 3'd0);
    issue_request(2, 1'b0, 7'd21, 4'hF, 32'h0, 3'd4);

    // Loads from all four threads in flight together
    wait_all_idle();
    for (int i = 0; i < `NUM_THREADS; i++)
      issue_request(i, 1'b1, 7'(40 + i), 4'hF, 32'h1357_9BDF ^ 32'(i * 32'h0101_0101), 3'd0);
    wait_all_idle();
    for (int i = 0; i < `NUM_THREADS; i++)
      issue_request(i, 1'b0, 7'(40 + i), 4'hF, 32'h0, 3'(7 - i));

    // Random mix over eight words per thread, each word written whole before its first load
    for (int n = 0; n < RANDOM_REQS; n++)
    begin
      rnd  = $random(seed);
      data = $random(seed);
      t    = int'(rnd[1:0]);
      word = {4'b1100, rnd[4:2]};
      if (!word_written[{rnd[1:0], word}])
        issue_request(t, 1'b1, word, 4'hF, data, 3'd0);
      else if (rnd[9:8] == 2'd0)
        issue_request(t, 1'b1, word, rnd[13:10], data, 3'd0);
      else
        issue_request(t, 1'b0, word, rnd[13:10], data, rnd[16:14]);
    end

    wait_all_idle();
    repeat (4) @(posedge CLK);
    $display("Summary: %0d requests, %0d mismatches, %0d other errors",
             req_count, mismatch_count, protocol_errors);
    if (mismatch_count == 0 && protocol_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: project.f
+incdir+source
source/bus_pkg.sv
source/axi_bus_if.sv
source/thread_slot_table.sv
source/axi_write_issue.sv
source/axi_read_issue.sv
source/load_formatter.sv
source/axi_ram_target.sv
source/thread_bus_unit.sv
tb/tb_thread_bus_unit.sv

// File: Makefile
# Verilator build, run and lint for the thread data-memory port

VERILATOR  ?= verilator
TOP        ?= tb_thread_bus_unit
RTL_TOP    ?= thread_bus_unit
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
PASS_MSG   ?= All tests passed
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the pass message shows up as a line of its own
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
